// File: hdl/rv_core_pkg.sv
package rv_core_pkg;

    localparam int unsigned ARCH_WIDTH = 32;

    typedef logic [ARCH_WIDTH-1:0] arch_width_t;
    typedef logic [ARCH_WIDTH-1:0] inst_width_t;
    typedef logic [4:0]            rf_addr_t;

    // ----------------------------------------
    // control encodings
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic {
        B_SEL_RS2,
        B_SEL_IMM
    } b_sel_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WBK  = 2'd2
    } fwd_sel_t;

    // ----------------------------------------
    // stage payloads
    typedef struct packed {
        rf_addr_t    rs1;
        rf_addr_t    rs2;
        rf_addr_t    rd;
        arch_width_t imm;
        alu_op_t     alu_op;
        b_sel_t      b_sel;
        logic        rd_we;
        logic        is_store;
    } decoded_t;

    typedef struct packed {
        logic flush;
        logic en;
    } stage_ctrl_t;

    // result holds the store address for SW
    typedef struct packed {
        arch_width_t result;
        arch_width_t store_data;
        rf_addr_t    rd;
        logic        rd_we;
        logic        is_store;
        logic        valid;
    } exe_mem_t;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

endpackage

// File: hdl/rv_decoder.sv
`timescale 1ns/100ps

module rv_decoder (
    input  rv_core_pkg::inst_width_t inst_i,
    output rv_core_pkg::decoded_t    decoded_o
);
    import rv_core_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        alt;
    arch_width_t imm_i;
    arch_width_t imm_s;
    arch_width_t imm_u;

    // funct3 to ALU op, alt picks SUB or SRA
    function automatic alu_op_t alu_sel(logic [2:0] f3, logic alt_op);
        case (f3)
            3'b000:  alu_sel = alt_op ? ALU_SUB : ALU_ADD;
            3'b001:  alu_sel = ALU_SLL;
            3'b010:  alu_sel = ALU_SLT;
            3'b011:  alu_sel = ALU_SLTU;
            3'b100:  alu_sel = ALU_XOR;
            3'b101:  alu_sel = alt_op ? ALU_SRA : ALU_SRL;
            3'b110:  alu_sel = ALU_OR;
            default: alu_sel = ALU_AND;
        endcase
    endfunction

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign alt    = inst_i[30];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_u = {inst_i[31:12], 12'h000};

    always_comb begin
        // unused fields stay x0 so they never match in forwarding
        decoded_o        = '0;
        decoded_o.alu_op = ALU_ADD;
        decoded_o.b_sel  = B_SEL_RS2;
        case (opcode)
            OPC_OP: begin
                decoded_o.rs1    = inst_i[19:15];
                decoded_o.rs2    = inst_i[24:20];
                decoded_o.rd     = inst_i[11:7];
                decoded_o.alu_op = alu_sel(funct3, alt);
                decoded_o.rd_we  = 1'b1;
            end
            OPC_OP_IMM: begin
                decoded_o.rs1    = inst_i[19:15];
                decoded_o.rd     = inst_i[11:7];
                decoded_o.imm    = imm_i;
                decoded_o.b_sel  = B_SEL_IMM;
                // bit 30 is part of the immediate except for shifts
                decoded_o.alu_op = alu_sel(funct3, alt && (funct3 == 3'b101));
                decoded_o.rd_we  = 1'b1;
            end
            OPC_LUI: begin
                // x0 + upper immediate
                decoded_o.rd    = inst_i[11:7];
                decoded_o.imm   = imm_u;
                decoded_o.b_sel = B_SEL_IMM;
                decoded_o.rd_we = 1'b1;
            end
            OPC_STORE: begin
                // word stores only
                if (funct3 == 3'b010) begin
                    decoded_o.rs1      = inst_i[19:15];
                    decoded_o.rs2      = inst_i[24:20];
                    decoded_o.imm      = imm_s;
                    decoded_o.b_sel    = B_SEL_IMM;
                    decoded_o.is_store = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/rv_reg_file.sv
`timescale 1ns/100ps

module rv_reg_file (
    input  logic                     clk,
    input  logic                     we_i,
    input  rv_core_pkg::rf_addr_t    addr_a_i,
    input  rv_core_pkg::rf_addr_t    addr_b_i,
    input  rv_core_pkg::rf_addr_t    addr_d_i,
    input  rv_core_pkg::arch_width_t data_d_i,
    output rv_core_pkg::arch_width_t data_a_o,
    output rv_core_pkg::arch_width_t data_b_o
);
    import rv_core_pkg::*;

    // no storage behind x0
    arch_width_t regs [1:31];

    always_ff @(posedge clk) begin
        if (we_i && (addr_d_i != '0)) begin
            regs[addr_d_i] <= data_d_i;
        end
    end

    // same-cycle write is not visible here, decode forwarding covers it
    assign data_a_o = (addr_a_i == '0) ? '0 : regs[addr_a_i];
    assign data_b_o = (addr_b_i == '0) ? '0 : regs[addr_b_i];

endmodule

// File: hdl/rv_operand_fwd.sv
`timescale 1ns/100ps

module rv_operand_fwd (
    input  rv_core_pkg::rf_addr_t rs1_dec_i,
    input  rv_core_pkg::rf_addr_t rs2_dec_i,
    input  rv_core_pkg::rf_addr_t rs1_exe_i,
    input  rv_core_pkg::rf_addr_t rs2_exe_i,
    input  rv_core_pkg::rf_addr_t rd_mem_i,
    input  rv_core_pkg::rf_addr_t rd_wbk_i,
    input  logic                  rd_we_mem_i,
    input  logic                  rd_we_wbk_i,
    output rv_core_pkg::fwd_sel_t fwd_rs1_dec_o,
    output rv_core_pkg::fwd_sel_t fwd_rs2_dec_o,
    output rv_core_pkg::fwd_sel_t fwd_rs1_exe_o,
    output rv_core_pkg::fwd_sel_t fwd_rs2_exe_o
);
    import rv_core_pkg::*;

    // x0 never matches
    function automatic logic hit(rf_addr_t rs, rf_addr_t rd, logic we);
        return we && (rs != '0) && (rs == rd);
    endfunction

    // ----------------------------------------
    // execute, youngest producer first
    assign fwd_rs1_exe_o = hit(rs1_exe_i, rd_mem_i, rd_we_mem_i) ? FWD_MEM :
                           hit(rs1_exe_i, rd_wbk_i, rd_we_wbk_i) ? FWD_WBK : FWD_NONE;
    assign fwd_rs2_exe_o = hit(rs2_exe_i, rd_mem_i, rd_we_mem_i) ? FWD_MEM :
                           hit(rs2_exe_i, rd_wbk_i, rd_we_wbk_i) ? FWD_WBK : FWD_NONE;

    // ----------------------------------------
    // decode, writeback only
    assign fwd_rs1_dec_o = hit(rs1_dec_i, rd_wbk_i, rd_we_wbk_i) ? FWD_WBK : FWD_NONE;
    assign fwd_rs2_dec_o = hit(rs2_dec_i, rd_wbk_i, rd_we_wbk_i) ? FWD_WBK : FWD_NONE;

endmodule

// File: hdl/rv_alu.sv
`timescale 1ns/100ps

module rv_alu (
    input  rv_core_pkg::alu_op_t     op_i,
    input  rv_core_pkg::arch_width_t a_i,
    input  rv_core_pkg::arch_width_t b_i,
    output rv_core_pkg::arch_width_t s_o
);
    import rv_core_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  s_o = a_i + b_i;
            ALU_SUB:  s_o = a_i - b_i;
            ALU_AND:  s_o = a_i & b_i;
            ALU_OR:   s_o = a_i | b_i;
            ALU_XOR:  s_o = a_i ^ b_i;
            ALU_SLL:  s_o = a_i << shamt;
            ALU_SRL:  s_o = a_i >> shamt;
            ALU_SRA:  s_o = arch_width_t'($signed(a_i) >>> shamt);
            // compares give 0 or 1
            ALU_SLT:  s_o = arch_width_t'($signed(a_i) < $signed(b_i));
            ALU_SLTU: s_o = arch_width_t'(a_i < b_i);
            default:  s_o = '0;
        endcase
    end

endmodule

// File: hdl/rv_pipe_ctrl.sv
`timescale 1ns/100ps

module rv_pipe_ctrl #(
    parameter int unsigned RST_FLUSH_CYCLES = 3
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     dmem_req_valid_i,
    input  logic                     dmem_req_ready_i,
    output logic                     inst_ready_o,
    output rv_core_pkg::stage_ctrl_t ctrl_dec_exe_o,
    output rv_core_pkg::stage_ctrl_t ctrl_exe_mem_o,
    output rv_core_pkg::stage_ctrl_t ctrl_mem_wbk_o,
    output rv_core_pkg::stage_ctrl_t ctrl_wbk_ret_o
);

    // one extra bit per stage behind the input gate
    localparam int unsigned SEQ_W = RST_FLUSH_CYCLES + 4;

    logic [SEQ_W-1:0] rst_seq;
    logic             stall;

    // ones at reset, zeros shift in from the bottom
    always_ff @(posedge clk) begin
        if (rst) begin
            rst_seq <= '1;
        end else begin
            rst_seq <= {rst_seq[SEQ_W-2:0], 1'b0};
        end
    end

    // store waiting on the memory freezes everything
    assign stall = dmem_req_valid_i && !dmem_req_ready_i;

    assign inst_ready_o = !rst_seq[RST_FLUSH_CYCLES-1] && !stall;

    // each stage leaves flush one edge after the one before it
    assign ctrl_dec_exe_o = '{flush: rst_seq[RST_FLUSH_CYCLES],     en: !stall};
    assign ctrl_exe_mem_o = '{flush: rst_seq[RST_FLUSH_CYCLES + 1], en: !stall};
    assign ctrl_mem_wbk_o = '{flush: rst_seq[RST_FLUSH_CYCLES + 2], en: !stall};
    assign ctrl_wbk_ret_o = '{flush: rst_seq[RST_FLUSH_CYCLES + 3], en: !stall};

endmodule

// File: hdl/rv_core.sv
`timescale 1ns/100ps

module rv_core #(
    parameter int unsigned DMEM_ADDR_W      = 16,
    parameter int unsigned RST_FLUSH_CYCLES = 3,
    localparam type dmem_req_t = struct packed {
        logic [DMEM_ADDR_W-1:0]   addr;
        rv_core_pkg::arch_width_t wdata;
    }
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     inst_valid_i,
    input  rv_core_pkg::inst_width_t inst_i,
    output logic                     inst_ready_o,
    output logic                     dmem_req_valid_o,
    output dmem_req_t                dmem_req_o,
    input  logic                     dmem_req_ready_i,
    output logic                     inst_retired_o
);
    import rv_core_pkg::*;

    stage_ctrl_t ctrl_dec_exe, ctrl_exe_mem, ctrl_mem_wbk, ctrl_wbk_ret;

    // back end state, read by the forwarding muxes
    exe_mem_t    em;
    arch_width_t wbk_result;
    rf_addr_t    wbk_rd;
    logic        wbk_rd_we;
    logic        wbk_valid;
    logic        ret_valid;

    function automatic arch_width_t fwd_mux(
        input fwd_sel_t    sel,
        input arch_width_t stage_val,
        input arch_width_t mem_val,
        input arch_width_t wbk_val
    );
        case (sel)
            FWD_MEM: fwd_mux = mem_val;
            FWD_WBK: fwd_mux = wbk_val;
            default: fwd_mux = stage_val;
        endcase
    endfunction

    rv_pipe_ctrl #(
        .RST_FLUSH_CYCLES (RST_FLUSH_CYCLES)
    ) u_pipe_ctrl (
        .clk              (clk),
        .rst              (rst),
        .dmem_req_valid_i (dmem_req_valid_o),
        .dmem_req_ready_i (dmem_req_ready_i),
        .inst_ready_o     (inst_ready_o),
        .ctrl_dec_exe_o   (ctrl_dec_exe),
        .ctrl_exe_mem_o   (ctrl_exe_mem),
        .ctrl_mem_wbk_o   (ctrl_mem_wbk),
        .ctrl_wbk_ret_o   (ctrl_wbk_ret)
    );

    // ----------------------------------------
    // decode
    inst_width_t inst_dec;
    logic        dec_valid;
    decoded_t    dec;
    arch_width_t rf_a, rf_b, rs1_val_dec, rs2_val_dec;
    fwd_sel_t    fwd_rs1_dec, fwd_rs2_dec, fwd_rs1_exe, fwd_rs2_exe;
    logic        rf_we;

    // accepted instruction, ready is low during the flush sequence
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (ctrl_dec_exe.en) begin
            dec_valid <= inst_valid_i && inst_ready_o;
            inst_dec  <= inst_i;
        end
    end

    rv_decoder u_decoder (
        .inst_i    (inst_dec),
        .decoded_o (dec)
    );

    // no repeated write while stalled
    assign rf_we = wbk_rd_we && ctrl_wbk_ret.en;

    rv_reg_file u_reg_file (
        .clk      (clk),
        .we_i     (rf_we),
        .addr_a_i (dec.rs1),
        .addr_b_i (dec.rs2),
        .addr_d_i (wbk_rd),
        .data_d_i (wbk_result),
        .data_a_o (rf_a),
        .data_b_o (rf_b)
    );

    assign rs1_val_dec = fwd_mux(fwd_rs1_dec, rf_a, em.result, wbk_result);
    assign rs2_val_dec = fwd_mux(fwd_rs2_dec, rf_b, em.result, wbk_result);

    // ----------------------------------------
    // decode / execute register
    decoded_t    de_dec;
    logic        de_valid;
    arch_width_t de_rs1_val, de_rs2_val;

    always_ff @(posedge clk) begin
        if (rst || ctrl_dec_exe.flush) begin
            de_valid <= 1'b0;
        end else if (ctrl_dec_exe.en) begin
            de_valid   <= dec_valid;
            de_dec     <= dec;
            de_rs1_val <= rs1_val_dec;
            de_rs2_val <= rs2_val_dec;
        end
    end

    rv_operand_fwd u_operand_fwd (
        .rs1_dec_i     (dec.rs1),
        .rs2_dec_i     (dec.rs2),
        .rs1_exe_i     (de_dec.rs1),
        .rs2_exe_i     (de_dec.rs2),
        .rd_mem_i      (em.rd),
        .rd_wbk_i      (wbk_rd),
        .rd_we_mem_i   (em.rd_we),
        .rd_we_wbk_i   (wbk_rd_we),
        .fwd_rs1_dec_o (fwd_rs1_dec),
        .fwd_rs2_dec_o (fwd_rs2_dec),
        .fwd_rs1_exe_o (fwd_rs1_exe),
        .fwd_rs2_exe_o (fwd_rs2_exe)
    );

    // ----------------------------------------
    // execute
    arch_width_t op_a_exe, rs2_val_exe, op_b_exe, alu_s, exe_result;

    assign op_a_exe    = fwd_mux(fwd_rs1_exe, de_rs1_val, em.result, wbk_result);
    assign rs2_val_exe = fwd_mux(fwd_rs2_exe, de_rs2_val, em.result, wbk_result);
    assign op_b_exe    = (de_dec.b_sel == B_SEL_IMM) ? de_dec.imm : rs2_val_exe;

    rv_alu u_alu (
        .op_i (de_dec.alu_op),
        .a_i  (op_a_exe),
        .b_i  (op_b_exe),
        .s_o  (alu_s)
    );

    // store address is rs1 + imm cut to the memory width
    assign exe_result = de_dec.is_store ? arch_width_t'(alu_s[DMEM_ADDR_W-1:0]) : alu_s;

    always_ff @(posedge clk) begin
        if (rst || ctrl_exe_mem.flush) begin
            em.valid    <= 1'b0;
            em.rd_we    <= 1'b0;
            em.is_store <= 1'b0;
        end else if (ctrl_exe_mem.en) begin
            em.result     <= exe_result;
            em.store_data <= rs2_val_exe;
            em.rd         <= de_dec.rd;
            em.rd_we      <= de_dec.rd_we && de_valid;
            em.is_store   <= de_dec.is_store && de_valid;
            em.valid      <= de_valid;
        end
    end

    // ----------------------------------------
    // memory
    assign dmem_req_valid_o = em.is_store;
    assign dmem_req_o.addr  = em.result[DMEM_ADDR_W-1:0];
    assign dmem_req_o.wdata = em.store_data;

    always_ff @(posedge clk) begin
        if (rst || ctrl_mem_wbk.flush) begin
            wbk_valid <= 1'b0;
            wbk_rd_we <= 1'b0;
        end else if (ctrl_mem_wbk.en) begin
            wbk_valid  <= em.valid;
            wbk_rd_we  <= em.rd_we;
            wbk_rd     <= em.rd;
            wbk_result <= em.result;
        end
    end

    // ----------------------------------------
    // retire
    always_ff @(posedge clk) begin
        if (rst || ctrl_wbk_ret.flush) begin
            ret_valid <= 1'b0;
        end else if (ctrl_wbk_ret.en) begin
            ret_valid <= wbk_valid;
        end
    end

    // held while stalled, so one pulse per instruction
    assign inst_retired_o = ret_valid && ctrl_wbk_ret.en;

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int unsigned HALF_PERIOD = 4,
    parameter int unsigned RST_CYCLES  = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // released just after an edge, like the other inputs
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// File: dv/rv_core_properties.sv
`timescale 1ns/100ps

module rv_core_properties #(
    parameter int unsigned DMEM_ADDR_W = 16
) (
    input logic                                              clk,
    input logic                                              rst,
    input logic                                              inst_ready_o,
    input logic                                              dmem_req_valid_o,
    input logic [DMEM_ADDR_W+rv_core_pkg::ARCH_WIDTH-1:0]    dmem_req_o,
    input logic                                              dmem_req_ready_i,
    input logic                                              inst_retired_o
);

    // outputs are unknown until the first reset edge
    logic rst_seen;

    always_ff @(posedge clk) begin
        if (rst) begin
            rst_seen <= 1'b1;
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        dmem_req_valid_o && !dmem_req_ready_i |=> $stable(dmem_req_o))
        else $error("data memory request changed while stalled");

    a_ready_in_rst: assert property (@(posedge clk) disable iff (rst_seen !== 1'b1)
        rst |-> !inst_ready_o)
        else $error("instruction ready high during reset");

    a_retire_in_rst: assert property (@(posedge clk) disable iff (rst_seen !== 1'b1)
        rst |-> !inst_retired_o)
        else $error("retire pulse during reset");

endmodule

// File: dv/tb_rv_core.sv
`timescale 1ns/100ps

module tb_rv_core;
    import rv_core_pkg::*;

    localparam int unsigned DMEM_ADDR_W      = 16;
    localparam int unsigned RST_FLUSH_CYCLES = 3;
    localparam logic [15:0] LFSR_SEED        = 16'd48;
    localparam int          WAIT_LIMIT       = 200;

    typedef struct packed {
        logic [DMEM_ADDR_W-1:0] addr;
        logic [31:0]            wdata;
    } store_t;

    logic        clk;
    logic        rst;
    logic        inst_valid_i;
    inst_width_t inst_i;
    logic        inst_ready_o;
    logic        dmem_req_valid_o;
    store_t      dmem_req_o;
    logic        dmem_req_ready_i;
    logic        inst_retired_o;

    // architectural state of the model
    logic [31:0] xreg [32];
    store_t      exp_q [$];
    logic [15:0] lfsr     = LFSR_SEED;
    int          accepted = 0;
    int          retired  = 0;
    int          errors   = 0;
    int          tests    = 0;
    logic        stall_en = 1'b0;
    logic        hung     = 1'b0;

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    rv_core #(
        .DMEM_ADDR_W      (DMEM_ADDR_W),
        .RST_FLUSH_CYCLES (RST_FLUSH_CYCLES)
    ) u_dut (
        .clk              (clk),
        .rst              (rst),
        .inst_valid_i     (inst_valid_i),
        .inst_i           (inst_i),
        .inst_ready_o     (inst_ready_o),
        .dmem_req_valid_o (dmem_req_valid_o),
        .dmem_req_o       (dmem_req_o),
        .dmem_req_ready_i (dmem_req_ready_i),
        .inst_retired_o   (inst_retired_o)
    );

    bind rv_core rv_core_properties #(.DMEM_ADDR_W(DMEM_ADDR_W)) u_props (
        .clk              (clk),
        .rst              (rst),
        .inst_ready_o     (inst_ready_o),
        .dmem_req_valid_o (dmem_req_valid_o),
        .dmem_req_o       (dmem_req_o),
        .dmem_req_ready_i (dmem_req_ready_i),
        .inst_retired_o   (inst_retired_o)
    );

    // ----------------------------------------
    // random bits, x16 + x14 + x13 + x11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic rf_addr_t nz_reg();
        rf_addr_t r;
        r = rf_addr_t'(rand_bits(5));
        return (r == 5'd0) ? 5'd1 : r;
    endfunction

    // ----------------------------------------
    // instruction encoders
    function automatic inst_width_t op_r(input logic [2:0] f3, input logic alt,
                                         input rf_addr_t rd, input rf_addr_t rs1,
                                         input rf_addr_t rs2);
        return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic inst_width_t op_i(input logic [2:0] f3, input logic [11:0] imm,
                                         input rf_addr_t rd, input rf_addr_t rs1);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic inst_width_t op_lui(input rf_addr_t rd, input logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic inst_width_t op_sw(input rf_addr_t rs2, input rf_addr_t rs1,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic inst_width_t rand_alu(input rf_addr_t rd, input rf_addr_t rs1);
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        f3  = 3'(rand_bits(3));
        alt = (f3 == 3'd0 || f3 == 3'd5) ? rand_bits(1) : 1'b0;
        if (rand_bits(1)) begin
            return op_r(f3, alt, rd, rs1, rf_addr_t'(rand_bits(5)));
        end
        imm = 12'(rand_bits(12));
        // shift amount in the low 5 bits, bit 30 picks arithmetic
        if (f3 == 3'd1 || f3 == 3'd5) begin
            imm = {1'b0, alt, 5'd0, imm[4:0]};
        end
        return op_i(f3, imm, rd, rs1);
    endfunction

    // dropped opcodes and narrow stores
    function automatic inst_width_t rand_noop();
        inst_width_t w;
        w = rand_bits(32);
        case (rand_bits(2))
            0: w[6:0] = 7'b0000011;
            1: w[6:0] = 7'b1100011;
            2: w[6:0] = 7'b1101111;
            default: begin
                w[6:0]   = OPC_STORE;
                w[14:12] = {2'b00, w[12]};
            end
        endcase
        return w;
    endfunction

    // ----------------------------------------
    // reference model, RV32I semantics
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = {31'd0, $signed(a) < $signed(b)};
            3'd3: r = {31'd0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $unsigned($signed(a) >>> b[4:0]);
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic void model_exec(input inst_width_t inst);
        logic [31:0] a, b, imm_i, imm_s, res, sum;
        logic        wr;
        store_t      st;
        a     = xreg[inst[19:15]];
        b     = xreg[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        wr    = 1'b1;
        res   = '0;
        case (inst[6:0])
            OPC_OP:     res = alu_ref(inst[14:12], inst[30], a, b);
            OPC_OP_IMM: res = alu_ref(inst[14:12], inst[30] && inst[14:12] == 3'd5, a, imm_i);
            OPC_LUI:    res = {inst[31:12], 12'd0};
            OPC_STORE: begin
                wr = 1'b0;
                if (inst[14:12] == 3'b010) begin
                    sum      = a + imm_s;
                    st.addr  = sum[DMEM_ADDR_W-1:0];
                    st.wdata = b;
                    exp_q.push_back(st);
                end
            end
            default: wr = 1'b0;
        endcase
        if (wr && inst[11:7] != 5'd0) begin
            xreg[inst[11:7]] = res;
        end
    endfunction

    // ----------------------------------------
    // stimulus, driven 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        dmem_req_ready_i = stall_en ? (rand_bits(2) != 0) : 1'b1;
    endtask

    task automatic send(input inst_width_t inst);
        int   n;
        logic taken;
        if (hung) begin
            return;
        end
        // occasional gap in valid
        if (rand_bits(2) == 0) begin
            n = rand_bits(2);
            repeat (n) next_cycle();
        end
        inst_i       = inst;
        inst_valid_i = 1'b1;
        taken        = 1'b0;
        n            = 0;
        while (!taken && n < WAIT_LIMIT) begin
            @(negedge clk);
            taken = inst_ready_o;
            next_cycle();
            n++;
        end
        inst_valid_i = 1'b0;
        if (taken) begin
            accepted++;
            model_exec(inst);
        end else begin
            $display("timeout: instruction %h was never accepted", inst);
            hung = 1'b1;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (!hung && (retired != accepted || exp_q.size() != 0) && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!hung && (retired != accepted || exp_q.size() != 0)) begin
            $display("timeout: pipeline did not drain, %0d of %0d retired, %0d stores missing",
                     retired, accepted, exp_q.size());
            hung = 1'b1;
        end
    endtask

    task automatic report(input string name, input int err0);
        tests++;
        if (errors == err0) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - err0);
        end
    endtask

    // ----------------------------------------
    // stores and retire pulses, sampled on the falling edge
    initial begin
        store_t exp;
        logic   req_held;
        store_t held_req;
        req_held = 1'b0;
        forever begin
            @(negedge clk);
            if (inst_retired_o) begin
                retired++;
            end
            if (dmem_req_valid_o) begin
                if (req_held && dmem_req_o != held_req) begin
                    errors++;
                    $display("Error %0t: request %h changed while stalled, was %h",
                             $time, dmem_req_o, held_req);
                end
                req_held = !dmem_req_ready_i;
                held_req = dmem_req_o;
                if (dmem_req_ready_i && exp_q.size() == 0) begin
                    errors++;
                    $display("store to %h seen with no store expected", dmem_req_o.addr);
                end else if (dmem_req_ready_i) begin
                    exp = exp_q.pop_front();
                    if (dmem_req_o != exp) begin
                        errors++;
                        $display("Error %0t: store addr %h data %h, expected addr %h data %h",
                                 $time, dmem_req_o.addr, dmem_req_o.wdata, exp.addr, exp.wdata);
                    end
                end
            end
        end
    end

    // ----------------------------------------
    // tests
    task automatic check_reset();
        int err0, n, flush_n;
        err0 = errors;
        n    = 0;
        @(negedge clk);
        while (rst && n < WAIT_LIMIT) begin
            if (inst_ready_o || dmem_req_valid_o || inst_retired_o) begin
                errors++;
                $display("Error %0t: core outputs active during reset", $time);
            end
            n++;
            @(negedge clk);
        end
        flush_n = 0;
        while (!rst && !inst_ready_o && flush_n < WAIT_LIMIT) begin
            if (dmem_req_valid_o || inst_retired_o) begin
                errors++;
                $display("Error %0t: core outputs active during flush", $time);
            end
            flush_n++;
            @(negedge clk);
        end
        if (rst || !inst_ready_o) begin
            $display("timeout: core never became ready after reset");
            hung = 1'b1;
        end else if (flush_n != RST_FLUSH_CYCLES) begin
            errors++;
            $display("Error %0t: %0d flush cycles, expected %0d", $time, flush_n,
                     RST_FLUSH_CYCLES);
        end
        report("reset", err0);
    endtask

    task automatic test_dependent();
        int       err0;
        rf_addr_t rd, prev;
        err0 = errors;
        // register file has no reset
        for (int r = 1; r < 32; r++) begin
            send(op_i(3'd0, 12'(rand_bits(12)), rf_addr_t'(r), 5'd0));
        end
        prev = 5'd1;
        for (int i = 0; i < 40; i++) begin
            rd = nz_reg();
            send(rand_alu(rd, prev));
            send(op_sw(rd, nz_reg(), 12'(rand_bits(12))));
            prev = rd;
        end
        drain();
        report("dependent", err0);
    endtask

    task automatic test_shift_compare();
        int         err0;
        logic [2:0] f3;
        logic       alt;
        rf_addr_t   ra, rb, rd;
        err0 = errors;
        for (int i = 0; i < 30; i++) begin
            ra = nz_reg();
            rb = nz_reg();
            rd = nz_reg();
            send(op_lui(ra, 20'(rand_bits(20))));
            send(op_i(3'd0, 12'(rand_bits(12)), ra, ra));
            send(op_lui(rb, 20'(rand_bits(20))));
            send(op_i(3'd0, 12'(rand_bits(12)), rb, rb));
            case (rand_bits(2))
                0: f3 = 3'd1;
                1: f3 = 3'd2;
                2: f3 = 3'd3;
                default: f3 = 3'd5;
            endcase
            alt = (f3 == 3'd5) ? rand_bits(1) : 1'b0;
            if (rand_bits(1)) begin
                send(op_r(f3, alt, rd, ra, rb));
            end else if (f3 == 3'd1 || f3 == 3'd5) begin
                send(op_i(f3, {1'b0, alt, 5'd0, 5'(rand_bits(5))}, rd, ra));
            end else begin
                send(op_i(f3, 12'(rand_bits(12)), rd, ra));
            end
            send(op_sw(rd, 5'd0, 12'(rand_bits(12))));
        end
        drain();
        report("lui_shift_slt", err0);
    endtask

    task automatic test_stalls();
        int       err0;
        rf_addr_t rd;
        err0     = errors;
        stall_en = 1'b1;
        for (int i = 0; i < 40; i++) begin
            rd = nz_reg();
            send(rand_alu(rd, nz_reg()));
            send(op_sw(rd, nz_reg(), 12'(rand_bits(12))));
            send(op_sw(nz_reg(), nz_reg(), 12'(rand_bits(12))));
        end
        drain();
        stall_en = 1'b0;
        report("stalls", err0);
    endtask

    task automatic test_x0_noop();
        int err0;
        err0 = errors;
        for (int i = 0; i < 20; i++) begin
            send(rand_alu(5'd0, nz_reg()));
            send(rand_noop());
            send(op_sw(5'd0, nz_reg(), 12'(rand_bits(12))));
        end
        drain();
        // extra cycles to catch stray pulses
        repeat (8) next_cycle();
        if (!hung && retired != accepted) begin
            errors++;
            $display("Error %0t: %0d retire pulses for %0d accepted instructions",
                     $time, retired, accepted);
        end
        report("x0_noop", err0);
    endtask

    initial begin
        inst_valid_i     = 1'b0;
        inst_i           = '0;
        dmem_req_ready_i = 1'b1;
        for (int r = 0; r < 32; r++) begin
            xreg[r] = '0;
        end
        check_reset();
        next_cycle();
        if (!hung) begin
            test_dependent();
        end
        if (!hung) begin
            test_shift_compare();
        end
        if (!hung) begin
            test_stalls();
        end
        if (!hung) begin
            test_x0_noop();
        end
        $display("tests run %0d, errors %0d, retired %0d", tests, errors, retired);
        if (errors == 0 && !hung) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: rv_core.f
hdl/rv_core_pkg.sv
hdl/rv_decoder.sv
hdl/rv_reg_file.sv
hdl/rv_operand_fwd.sv
hdl/rv_alu.sv
hdl/rv_pipe_ctrl.sv
hdl/rv_core.sv
dv/tb_clk_gen.sv
dv/rv_core_properties.sv
dv/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  # RTL in compile order
  - hdl/rv_core_pkg.sv
  - hdl/rv_decoder.sv
  - hdl/rv_reg_file.sv
  - hdl/rv_operand_fwd.sv
  - hdl/rv_alu.sv
  - hdl/rv_pipe_ctrl.sv
  - hdl/rv_core.sv

  # testbench
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/rv_core_properties.sv
      - dv/tb_rv_core.sv
